// ==== source/cpuPkg.sv ====
// Shared types and opcode constants for the 16-bit pipelined core
// Instruction layout
//   [15:12] opcode
//   [11:9]  destination, stored register (ST) or tested register (BEQZ)
//   [8:6]   first source
//   [5:3]   second source
//   [5:0]   signed immediate, [8:0] signed branch offset
package cpuPkg;

	// Register value, ALU result or bus data
	typedef logic [15:0] dataWord;
	typedef logic [15:0] instrWord;
	// Word address of an instruction
	typedef logic [15:0] pcWord;
	typedef logic [2:0] regIdx;
	typedef logic [3:0] opcode;

	// Opcodes 10 to 15 are illegal
	localparam opcode opNop = 4'd0;
	localparam opcode opAdd = 4'd1;
	localparam opcode opSub = 4'd2;
	localparam opcode opAnd = 4'd3;
	localparam opcode opXor = 4'd4;
	localparam opcode opAddi = 4'd5;
	localparam opcode opLd = 4'd6;
	localparam opcode opSt = 4'd7;
	localparam opcode opBeqz = 4'd8;
	localparam opcode opHalt = 4'd9;

endpackage

// ==== source/busTimer.sv ====
// Wait-state timer for a bus access
// Counts cycles while an access is open, flags expiry at the limit
`timescale 1ns/1ps

module busTimer #(
	parameter int timeoutCycles = 16
) (
	input logic clk,
	input logic rstN,
	input logic counting,
	output logic expired
);

	localparam int cntW = $clog2(timeoutCycles + 1);
	localparam logic [cntW-1:0] limit = cntW'(timeoutCycles);

	logic [cntW-1:0] count;

	// Saturates at the limit, cleared between accesses
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			count <= '0;
		else if (!counting)
			count <= '0;
		else if (count != limit)
			count <= count + 1'b1;
	end

	assign expired = counting && count == limit;

	countInRange: assert property (@(posedge clk) disable iff (!rstN) count <= limit);

endmodule

// ==== source/fetchStage.sv ====
// Fetch stage
// Program counter with branch redirect, combinational instruction port
// and the fetch-to-decode register
`timescale 1ns/1ps

module fetchStage (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic redirect,
	input cpuPkg::pcWord redirectPc,
	input cpuPkg::instrWord instr,
	output cpuPkg::pcWord instrAdr,
	output cpuPkg::instrWord fdInstr,
	output cpuPkg::pcWord fdPc,
	output logic fdValid
);

	cpuPkg::pcWord pc;

	assign instrAdr = pc;

	// Redirect wins over hold, the word in flight becomes a bubble
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			fdValid <= 1'b0;
		end else if (redirect) begin
			pc <= redirectPc;
			fdValid <= 1'b0;
		end else if (!hold) begin
			pc <= pc + 1'b1;
			fdValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold && !redirect) begin
			fdInstr <= instr;
			fdPc <= pc;
		end
	end

endmodule

// ==== source/decodeStage.sv ====
// Decode stage
// Field decode, immediate sign extension, register file with write bypass,
// load-use hazard detection and the decode-to-execute register
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic flush,
	input cpuPkg::instrWord fdInstr,
	input cpuPkg::pcWord fdPc,
	input logic fdValid,
	input logic wbWrite,
	input cpuPkg::regIdx wbDest,
	input cpuPkg::dataWord wbValue,
	output logic hazardStall,
	output logic dxValid,
	output cpuPkg::opcode dxOp,
	output cpuPkg::regIdx dxDest,
	output cpuPkg::regIdx dxSrcA,
	output cpuPkg::regIdx dxSrcB,
	output cpuPkg::dataWord dxA,
	output cpuPkg::dataWord dxB,
	output cpuPkg::dataWord dxImm,
	output cpuPkg::pcWord dxPc
);

	cpuPkg::dataWord regFile [8];
	cpuPkg::opcode op;
	cpuPkg::regIdx srcA;
	cpuPkg::regIdx srcB;
	cpuPkg::regIdx dest;
	cpuPkg::dataWord imm;

	// A write in the same cycle is seen by the read ports
	function automatic cpuPkg::dataWord readReg(input cpuPkg::regIdx idx);
		if (idx == '0)
			return '0;
		if (wbWrite && wbDest == idx)
			return wbValue;
		return regFile[idx];
	endfunction

	assign op = fdInstr[15:12];

	// Unused sources and non-writing destinations stay at register 0
	always_comb begin
		srcA = '0;
		srcB = '0;
		dest = '0;
		imm = {{10{fdInstr[5]}}, fdInstr[5:0]};
		case (op)
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opXor: begin
				srcA = fdInstr[8:6];
				srcB = fdInstr[5:3];
				dest = fdInstr[11:9];
			end
			cpuPkg::opAddi, cpuPkg::opLd: begin
				srcA = fdInstr[8:6];
				dest = fdInstr[11:9];
			end
			cpuPkg::opSt: begin
				srcA = fdInstr[8:6];
				srcB = fdInstr[11:9];
			end
			cpuPkg::opBeqz: begin
				srcA = fdInstr[11:9];
				imm = {{7{fdInstr[8]}}, fdInstr[8:0]};
			end
			default: ;
		endcase
	end

	// Load in execute feeding a source of the instruction here
	assign hazardStall = fdValid && dxValid && dxOp == cpuPkg::opLd && dxDest != '0 &&
		(srcA == dxDest || srcB == dxDest);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++)
				regFile[i] <= '0;
		end else if (wbWrite && wbDest != '0) begin
			regFile[wbDest] <= wbValue;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			dxValid <= 1'b0;
		else if (flush)
			dxValid <= 1'b0;
		else if (!hold)
			dxValid <= fdValid && !hazardStall;
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			dxOp <= op;
			dxDest <= dest;
			dxSrcA <= srcA;
			dxSrcB <= srcB;
			dxA <= readReg(srcA);
			dxB <= readReg(srcB);
			dxImm <= imm;
			dxPc <= fdPc;
		end
	end

endmodule

// ==== source/executeStage.sv ====
// Execute stage
// Operand forwarding from memory and writeback, ALU, branch resolution
// and the execute-to-memory register
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic dxValid,
	input cpuPkg::opcode dxOp,
	input cpuPkg::regIdx dxDest,
	input cpuPkg::regIdx dxSrcA,
	input cpuPkg::regIdx dxSrcB,
	input cpuPkg::dataWord dxA,
	input cpuPkg::dataWord dxB,
	input cpuPkg::dataWord dxImm,
	input cpuPkg::pcWord dxPc,
	input logic wbWrite,
	input cpuPkg::regIdx wbDest,
	input cpuPkg::dataWord wbValue,
	output logic redirect,
	output cpuPkg::pcWord redirectPc,
	output logic emValid,
	output cpuPkg::opcode emOp,
	output cpuPkg::regIdx emDest,
	output cpuPkg::dataWord emResult,
	output cpuPkg::dataWord emStore
);

	cpuPkg::dataWord opA;
	cpuPkg::dataWord opB;
	cpuPkg::dataWord aluOut;

	// Youngest producer first; load data is not ready in the memory stage
	function automatic cpuPkg::dataWord pickOperand(input cpuPkg::regIdx src,
		input cpuPkg::dataWord regVal);
		if (src == '0)
			return regVal;
		if (emValid && emDest == src && emOp != cpuPkg::opLd)
			return emResult;
		if (wbWrite && wbDest == src)
			return wbValue;
		return regVal;
	endfunction

	always_comb begin
		opA = pickOperand(dxSrcA, dxA);
		opB = pickOperand(dxSrcB, dxB);
		case (dxOp)
			cpuPkg::opAdd: aluOut = opA + opB;
			cpuPkg::opSub: aluOut = opA - opB;
			cpuPkg::opAnd: aluOut = opA & opB;
			cpuPkg::opXor: aluOut = opA ^ opB;
			// Load and store addresses come from base plus offset
			cpuPkg::opAddi, cpuPkg::opLd, cpuPkg::opSt: aluOut = opA + dxImm;
			default: aluOut = '0;
		endcase
	end

	// Taken only when the stage can advance
	assign redirect = dxValid && dxOp == cpuPkg::opBeqz && opA == '0 && !hold;
	assign redirectPc = dxPc + 1'b1 + dxImm;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			emValid <= 1'b0;
		else if (!hold)
			emValid <= dxValid;
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			emOp <= dxOp;
			emDest <= dxDest;
			emResult <= aluOut;
			emStore <= opB;
		end
	end

	// Word behind a taken branch arrives here as a bubble
	redirectFlushesDecode: assert property (@(posedge clk) disable iff (!rstN)
		redirect |=> !dxValid);

endmodule

// ==== source/busMaster.sv ====
// Memory stage
// Wishbone classic master for loads and stores, halt and fault handling,
// writeback select and the memory-to-writeback register
`timescale 1ns/1ps

module busMaster #(
	parameter int timeoutCycles = 16
) (
	input logic clk,
	input logic rstN,
	input logic emValid,
	input cpuPkg::opcode emOp,
	input cpuPkg::regIdx emDest,
	input cpuPkg::dataWord emResult,
	input cpuPkg::dataWord emStore,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output cpuPkg::dataWord wbAdr,
	output cpuPkg::dataWord wbDatO,
	input cpuPkg::dataWord wbDatI,
	input logic wbAck,
	output logic memStall,
	output logic halted,
	output logic err,
	output logic wbWrite,
	output cpuPkg::regIdx wbDest,
	output cpuPkg::dataWord wbValue
);

	typedef enum logic [1:0] {idle, access, halt, fault} busState;

	busState state;
	busState nextState;
	logic isLd;
	logic isMem;
	logic expired;

	assign isLd = emOp == cpuPkg::opLd;
	assign isMem = emValid && (isLd || emOp == cpuPkg::opSt);

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (isMem)
					nextState = access;
				else if (emValid && emOp == cpuPkg::opHalt)
					nextState = halt;
				else if (emValid && emOp > cpuPkg::opHalt)
					nextState = fault;
			end
			access: begin
				if (wbAck)
					nextState = idle;
				else if (expired)
					nextState = fault;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= idle;
		else
			state <= nextState;
	end

	// Setup cycle plus every wait cycle; the ack cycle lets the pipe move
	assign memStall = isMem && (state == idle || (state == access && !wbAck));
	assign halted = state == halt || state == fault;
	assign err = state == fault;

	// Address and data come straight from the frozen execute-to-memory register
	assign wbCyc = state == access;
	assign wbStb = state == access;
	assign wbWe = wbCyc && emOp == cpuPkg::opSt;
	assign wbAdr = emResult;
	assign wbDatO = emStore;

	busTimer #(
		.timeoutCycles(timeoutCycles)
	) i_busTimer (
		.clk(clk),
		.rstN(rstN),
		.counting(wbCyc),
		.expired(expired)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			wbWrite <= 1'b0;
		else if (halted)
			wbWrite <= 1'b0;
		else if (!memStall)
			wbWrite <= emValid && emDest != '0;
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			wbDest <= emDest;
			wbValue <= isLd ? wbDatI : emResult;
		end
	end

	stbOnlyForMemOp: assert property (@(posedge clk) disable iff (!rstN)
		wbStb |-> wbCyc && isMem);
	adrHeldUntilAck: assert property (@(posedge clk) disable iff (!rstN)
		wbCyc && !wbAck |=> $stable(wbAdr) && $stable(wbDatO));

endmodule

// ==== source/pipeCpu.sv ====
// Five-stage 16-bit pipelined core
// Combinational instruction port, Wishbone classic data port
`timescale 1ns/1ps

module pipeCpu #(
	parameter int timeoutCycles = 16
) (
	input logic clk,
	input logic rstN,
	output cpuPkg::pcWord instrAdr,
	input cpuPkg::instrWord instr,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output cpuPkg::dataWord wbAdr,
	output cpuPkg::dataWord wbDatO,
	input cpuPkg::dataWord wbDatI,
	input logic wbAck,
	output logic halted,
	output logic err
);

	logic memStall, hazardStall, redirect;
	cpuPkg::pcWord redirectPc;

	// Fetch to decode
	cpuPkg::instrWord fdInstr;
	cpuPkg::pcWord fdPc;
	logic fdValid;

	// Decode to execute
	logic dxValid;
	cpuPkg::opcode dxOp;
	cpuPkg::regIdx dxDest, dxSrcA, dxSrcB;
	cpuPkg::dataWord dxA, dxB, dxImm;
	cpuPkg::pcWord dxPc;

	// Execute to memory, and writeback
	logic emValid, wbWrite;
	cpuPkg::opcode emOp;
	cpuPkg::regIdx emDest, wbDest;
	cpuPkg::dataWord emResult, emStore, wbValue;

	wire frontHold = memStall | hazardStall | halted;
	wire backHold = memStall | halted;

	fetchStage i_fetch (.clk(clk), .rstN(rstN), .hold(frontHold), .redirect(redirect),
		.redirectPc(redirectPc), .instr(instr), .instrAdr(instrAdr), .fdInstr(fdInstr),
		.fdPc(fdPc), .fdValid(fdValid));

	decodeStage i_decode (.clk(clk), .rstN(rstN), .hold(backHold), .flush(redirect),
		.fdInstr(fdInstr), .fdPc(fdPc), .fdValid(fdValid), .wbWrite(wbWrite),
		.wbDest(wbDest), .wbValue(wbValue), .hazardStall(hazardStall), .dxValid(dxValid),
		.dxOp(dxOp), .dxDest(dxDest), .dxSrcA(dxSrcA), .dxSrcB(dxSrcB), .dxA(dxA),
		.dxB(dxB), .dxImm(dxImm), .dxPc(dxPc));

	executeStage i_execute (.clk(clk), .rstN(rstN), .hold(backHold), .dxValid(dxValid),
		.dxOp(dxOp), .dxDest(dxDest), .dxSrcA(dxSrcA), .dxSrcB(dxSrcB), .dxA(dxA),
		.dxB(dxB), .dxImm(dxImm), .dxPc(dxPc), .wbWrite(wbWrite), .wbDest(wbDest),
		.wbValue(wbValue), .redirect(redirect), .redirectPc(redirectPc),
		.emValid(emValid), .emOp(emOp), .emDest(emDest), .emResult(emResult),
		.emStore(emStore));

	busMaster #(.timeoutCycles(timeoutCycles)) i_busMaster (.clk(clk), .rstN(rstN),
		.emValid(emValid), .emOp(emOp), .emDest(emDest), .emResult(emResult),
		.emStore(emStore), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck), .memStall(memStall),
		.halted(halted), .err(err), .wbWrite(wbWrite), .wbDest(wbDest), .wbValue(wbValue));

endmodule

// ==== dv/pipeCpuTb.sv ====
// Testbench for the five-stage pipelined core
// Instruction ROM, Wishbone memory with random wait states, reference
// interpreter for the expected store sequence and a bus monitor that compares
`timescale 1ns/1ps

module pipeCpuTb;

	localparam int timeoutCycles = 16;

	logic clk;
	logic rstN;
	cpuPkg::pcWord instrAdr;
	cpuPkg::instrWord instr;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	cpuPkg::dataWord wbAdr;
	cpuPkg::dataWord wbDatO;
	cpuPkg::dataWord wbDatI;
	logic wbAck;
	logic halted;
	logic err;

	cpuPkg::instrWord rom [256];
	cpuPkg::dataWord mem [256];
	cpuPkg::dataWord expAdr [$];
	cpuPkg::dataWord expDat [$];
	int loadPtr;
	int storeIdx;
	int waitLeft;
	logic accessOpen;
	logic neverAck;
	int unsigned lcgState;

	pipeCpu #(.timeoutCycles(timeoutCycles)) i_pipeCpu (.clk(clk), .rstN(rstN),
		.instrAdr(instrAdr), .instr(instr), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatO(wbDatO), .wbDatI(wbDatI), .wbAck(wbAck),
		.halted(halted), .err(err));

	// Combinational instruction port
	assign instr = rom[instrAdr[7:0]];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int unsigned nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16;
	endfunction

	function automatic cpuPkg::dataWord fillWord(input logic [7:0] a);
		return {a, ~a} ^ 16'h3C5A;
	endfunction

	function automatic cpuPkg::instrWord encR(input cpuPkg::opcode op, input int d,
		input int a, input int b);
		return {op, 3'(d), 3'(a), 3'(b), 3'b000};
	endfunction

	function automatic cpuPkg::instrWord encI(input cpuPkg::opcode op, input int d,
		input int a, input int imm);
		return {op, 3'(d), 3'(a), 6'(imm)};
	endfunction

	function automatic cpuPkg::instrWord encB(input int d, input int off);
		return {cpuPkg::opBeqz, 3'(d), 9'(off)};
	endfunction

	// Interprets the ROM; 0 ends in HALT, 1 in an illegal opcode, 2 runs away
	function automatic int runReference();
		cpuPkg::dataWord regs [8];
		cpuPkg::dataWord refMem [256];
		cpuPkg::pcWord pc;
		cpuPkg::instrWord ins;
		cpuPkg::dataWord adr;
		cpuPkg::regIdx d;
		cpuPkg::regIdx a;
		cpuPkg::regIdx b;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			refMem[i] = fillWord(8'(i));
		expAdr.delete();
		expDat.delete();
		pc = '0;
		for (int step = 0; step < 1000; step++) begin
			ins = rom[pc[7:0]];
			d = ins[11:9];
			a = ins[8:6];
			b = ins[5:3];
			adr = regs[a] + {{10{ins[5]}}, ins[5:0]};
			pc = pc + 16'd1;
			case (ins[15:12])
				cpuPkg::opNop: ;
				cpuPkg::opAdd: regs[d] = regs[a] + regs[b];
				cpuPkg::opSub: regs[d] = regs[a] - regs[b];
				cpuPkg::opAnd: regs[d] = regs[a] & regs[b];
				cpuPkg::opXor: regs[d] = regs[a] ^ regs[b];
				cpuPkg::opAddi: regs[d] = adr;
				cpuPkg::opLd: regs[d] = refMem[adr[7:0]];
				cpuPkg::opSt: begin
					expAdr.push_back(adr);
					expDat.push_back(regs[d]);
					refMem[adr[7:0]] = regs[d];
				end
				cpuPkg::opBeqz: begin
					if (regs[d] == '0)
						pc = pc + {{7{ins[8]}}, ins[8:0]};
				end
				cpuPkg::opHalt: return 0;
				default: return 1;
			endcase
			regs[0] = '0;
		end
		return 2;
	endfunction

	task automatic abortRun(input string why);
		$display("%0t: %s", $time, why);
		$display("tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkWord(input string name, input cpuPkg::dataWord got,
		input cpuPkg::dataWord exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
			abortRun("value check failed");
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
			abortRun("flag check failed");
		end
	endtask

	task automatic clearRom();
		for (int i = 0; i < 256; i++)
			rom[i] = '0;
		loadPtr = 0;
	endtask

	task automatic put(input cpuPkg::instrWord w);
		rom[loadPtr] = w;
		loadPtr++;
	endtask

	// Fresh memory image and 10 reset cycles
	task automatic resetCore();
		@(posedge clk);
		rstN <= 1'b0;
		storeIdx = 0;
		for (int i = 0; i < 256; i++)
			mem[i] = fillWord(8'(i));
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
	endtask

	task automatic runProgram(input string name);
		int endCode;
		int cycles;
		endCode = runReference();
		if (endCode == 2)
			abortRun("reference interpreter did not reach an end");
		resetCore();
		cycles = 0;
		while (!halted && cycles < 3000) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted)
			abortRun("timeout waiting for halted");
		// Quiet period with no further bus writes allowed
		repeat (8) @(negedge clk);
		checkFlag("halted", halted, 1'b1);
		checkFlag("err", err, endCode == 1);
		checkWord("store count", cpuPkg::dataWord'(storeIdx), cpuPkg::dataWord'(expAdr.size()));
		$display("%s program done, %0d stores", name, storeIdx);
	endtask

	// Wishbone slave with 0 to 3 wait states per access
	always @(posedge clk) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			accessOpen = 1'b0;
		end else if (wbAck) begin
			wbAck <= 1'b0;
		end else if (wbCyc && wbStb && !neverAck) begin
			if (!accessOpen) begin
				accessOpen = 1'b1;
				waitLeft = int'(nextRand() % 4);
			end
			if (waitLeft == 0) begin
				accessOpen = 1'b0;
				wbAck <= 1'b1;
				if (wbWe)
					mem[wbAdr[7:0]] = wbDatO;
				else
					wbDatI <= mem[wbAdr[7:0]];
			end else begin
				waitLeft--;
			end
		end
	end

	// Every completed write against the reference sequence
	always @(negedge clk) begin
		if (rstN && wbCyc && wbStb && wbWe && wbAck) begin
			if (storeIdx >= expAdr.size())
				abortRun("store on the bus beyond the expected sequence");
			checkWord("wbAdr", wbAdr, expAdr[storeIdx]);
			checkWord("wbDatO", wbDatO, expDat[storeIdx]);
			storeIdx++;
		end
	end

	initial begin
		int cycles;
		rstN = 1'b0;
		wbAck = 1'b0;
		wbDatI = '0;
		neverAck = 1'b0;
		accessOpen = 1'b0;
		waitLeft = 0;
		storeIdx = 0;
		lcgState = 67303;
		clearRom();

		// Back-to-back ALU dependencies
		put(encI(cpuPkg::opAddi, 1, 0, 7));
		put(encI(cpuPkg::opAddi, 2, 1, -3));
		put(encR(cpuPkg::opAdd, 3, 1, 2));
		put(encI(cpuPkg::opSt, 3, 0, 0));
		put(encR(cpuPkg::opSub, 4, 3, 1));
		put(encR(cpuPkg::opAnd, 5, 4, 3));
		put(encR(cpuPkg::opXor, 6, 5, 2));
		put(encI(cpuPkg::opAddi, 7, 6, 31));
		put(encI(cpuPkg::opSt, 4, 0, 1));
		put(encI(cpuPkg::opSt, 5, 0, 2));
		put(encI(cpuPkg::opSt, 6, 0, 3));
		put(encI(cpuPkg::opSt, 7, 0, 4));
		put(encI(cpuPkg::opSt, 2, 1, 5));
		put({cpuPkg::opHalt, 12'h000});
		runProgram("alu");

		// Load followed at once by its use
		clearRom();
		put(encI(cpuPkg::opAddi, 1, 0, 20));
		put(encI(cpuPkg::opLd, 2, 1, 3));
		put(encR(cpuPkg::opAdd, 3, 2, 1));
		put(encI(cpuPkg::opSt, 3, 0, 0));
		put(encI(cpuPkg::opLd, 4, 0, 0));
		put(encI(cpuPkg::opAddi, 5, 4, 1));
		put(encI(cpuPkg::opSt, 5, 1, -1));
		put(encI(cpuPkg::opLd, 6, 0, 5));
		put(encI(cpuPkg::opSt, 6, 0, 6));
		put({cpuPkg::opHalt, 12'h000});
		runProgram("load-use");

		// Countdown loop with word 7 in a taken branch shadow
		clearRom();
		put(encI(cpuPkg::opAddi, 1, 0, 3));
		put(encI(cpuPkg::opAddi, 2, 0, 0));
		put(encR(cpuPkg::opAdd, 2, 2, 1));
		put(encI(cpuPkg::opSt, 2, 1, 8));
		put(encI(cpuPkg::opAddi, 1, 1, -1));
		put(encB(1, 2));
		put(encB(0, -5));
		put(encI(cpuPkg::opSt, 1, 0, 30));
		put(encI(cpuPkg::opSt, 2, 0, 31));
		put({cpuPkg::opHalt, 12'h000});
		runProgram("branch");

		clearRom();
		put(encI(cpuPkg::opAddi, 1, 0, 9));
		put(encI(cpuPkg::opSt, 1, 0, 2));
		put({cpuPkg::opHalt, 12'h000});
		put(encI(cpuPkg::opSt, 1, 0, 3));
		put(encI(cpuPkg::opSt, 1, 0, 4));
		runProgram("halt");

		// Opcode 11 is illegal
		clearRom();
		put(encI(cpuPkg::opAddi, 1, 0, -2));
		put(encI(cpuPkg::opSt, 1, 0, 0));
		put(encI(cpuPkg::opSt, 1, 0, 1));
		put(16'hB000);
		put(encI(cpuPkg::opSt, 1, 0, 2));
		put({cpuPkg::opHalt, 12'h000});
		runProgram("illegal");

		// Slave never acknowledges so the timer must fault the core
		clearRom();
		put(encI(cpuPkg::opAddi, 1, 0, 4));
		put(encI(cpuPkg::opSt, 1, 1, 0));
		put({cpuPkg::opHalt, 12'h000});
		neverAck = 1'b1;
		expAdr.delete();
		expDat.delete();
		resetCore();
		cycles = 0;
		while (!wbCyc && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (!wbCyc)
			abortRun("store never opened a bus cycle");
		checkFlag("wbWe", wbWe, 1'b1);
		cycles = 0;
		while (!err && cycles < timeoutCycles + 3) begin
			checkFlag("wbCyc", wbCyc, 1'b1);
			checkFlag("wbStb", wbStb, 1'b1);
			@(negedge clk);
			cycles++;
		end
		if (cycles < timeoutCycles || cycles > timeoutCycles + 2)
			abortRun("err did not rise within the bus timeout window");
		checkFlag("halted", halted, 1'b1);
		$display("bus timeout done after %0d cycles", cycles);

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== all.f ====
source/cpuPkg.sv
source/busTimer.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/busMaster.sv
source/pipeCpu.sv
dv/pipeCpuTb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module pipeCpuTb -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv

clean:
	rm -rf obj_dir
